// ==== Bender.yml ====
package:
  name: cache_2way

sources:
  - src/cache_pkg.sv
  - src/cache_data_ram.sv
  - src/tag_cam.sv
  - src/set_lru_policy.sv
  - src/word_fifo.sv
  - src/wb_block_master.sv
  - src/cache_2way_controller.sv
  - src/cache_top.sv
  - target: test
    files:
      - tb/wb_mem_model.sv
      - tb/cache_tb.sv

// ==== list.f ====
src/cache_pkg.sv
src/cache_data_ram.sv
src/tag_cam.sv
src/set_lru_policy.sv
src/word_fifo.sv
src/wb_block_master.sv
src/cache_2way_controller.sv
src/cache_top.sv
tb/wb_mem_model.sv
tb/cache_tb.sv

// ==== src/cache_2way_controller.sv ====
`timescale 1ns/1ps

module cache_2way_controller (
	input  logic                             clock_i,
	input  logic                             resetn_i,
	// core request
	input  logic                             core_req_i,
	input  logic                             core_we_i,
	input  logic [cache_pkg::BW_TAG-1:0]     core_tag_i,
	input  logic [cache_pkg::BW_GRP-1:0]     core_grp_i,
	input  logic [cache_pkg::BW_BLOCK-1:0]   core_word_i,
	input  logic [31:0]                      core_data_i,
	output logic                             core_valid_o,
	output logic                             core_done_o,
	// tag cam
	input  logic                             cam_hit_i,
	input  logic [cache_pkg::BW_FRAME-1:0]   cam_frame_i,
	input  logic [cache_pkg::BW_TAG-1:0]     cam_tag_i,
	output logic                             cam_wren_o,
	output logic [cache_pkg::BW_FRAME-1:0]   cam_frame_o,
	// data ram
	input  logic [31:0]                      ram_data_i,
	output logic [cache_pkg::BW_RAM_ADDR-1:0] ram_addr_o,
	output logic                             ram_we_o,
	output logic [31:0]                      ram_data_o,
	// read and write buffers
	input  logic                             rbuf_empty_i,
	input  logic [31:0]                      rbuf_data_i,
	output logic                             rbuf_pop_o,
	input  logic                             wbuf_full_i,
	output logic                             wbuf_push_o,
	output logic [31:0]                      wbuf_data_o,
	// replacement unit
	input  logic                             lru_done_i,
	input  logic [cache_pkg::BW_FRAME-1:0]   lru_frame_i,
	output logic                             lru_hit_o,
	output logic                             lru_miss_o,
	// block commands
	input  logic                             mem_ready_i,
	output logic                             mem_req_o,
	output logic                             mem_rw_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] mem_addr_o,
	// performance
	output logic                             flag_hit_o,
	output logic                             flag_miss_o,
	output logic                             flag_writeback_o
);

	import cache_pkg::*;

	ctrl_state_t                 state_q;
	logic [CACHE_BLOCKS-1:0]     dirty_q;      // set on a store hit
	logic                        replay_q;     // miss in service, replay as hit
	logic                        we_q;         // write enable of the stalled request
	logic [BW_BLOCK-1:0]         cnt_q;        // words moved so far
	logic                        wb_pend_q;    // write command still to issue
	logic [BW_WORD_ADDR-1:0]     wb_addr_q;    // old block address of the victim
	logic [BW_FRAME-1:0]         victim_q;
	logic                        victim_rdy_q;
	logic                        req_we;
	logic                        last_word;

	assign req_we    = replay_q ? we_q : core_we_i;
	assign last_word = (cnt_q == BW_BLOCK'(BLOCK_WORDS - 1));

	// buffer handshakes follow the occupancy flags directly
	assign rbuf_pop_o  = (state_q == ST_READ_BUFFER) && !rbuf_empty_i;
	assign wbuf_push_o = (state_q == ST_WRITE_BUFFER) && !wbuf_full_i;
	assign wbuf_data_o = ram_data_i;      // ram reads at the registered address

	assign lru_hit_o  = flag_hit_o;       // hit frame rides on ram_addr_o
	assign lru_miss_o = flag_miss_o;

	// ------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q          <= ST_NORMAL;
			dirty_q          <= '0;
			replay_q         <= 1'b0;
			cnt_q            <= '0;
			wb_pend_q        <= 1'b0;
			victim_rdy_q     <= 1'b0;
			core_valid_o     <= 1'b0;
			core_done_o      <= 1'b1;
			cam_wren_o       <= 1'b0;
			ram_we_o         <= 1'b0;
			mem_req_o        <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
		end else begin
			// strobes default low
			core_valid_o     <= 1'b0;
			cam_wren_o       <= 1'b0;
			ram_we_o         <= 1'b0;
			mem_req_o        <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;

			if (lru_done_i) begin           // victim arrives one cycle after the miss
				victim_q     <= lru_frame_i;
				victim_rdy_q <= 1'b1;
			end

			case (state_q)
				ST_NORMAL: begin
					// skip the cycle in which a fresh tag is still being written
					if (core_req_i && !cam_wren_o) begin
						if (cam_hit_i) begin
							flag_hit_o   <= 1'b1;
							core_valid_o <= 1'b1;
							core_done_o  <= 1'b1;
							replay_q     <= 1'b0;
							ram_addr_o   <= {cam_frame_i, core_word_i};
							ram_we_o     <= req_we;
							ram_data_o   <= core_data_i;
							if (req_we) begin
								dirty_q[cam_frame_i] <= 1'b1;
							end
						end else if (!replay_q) begin
							flag_miss_o <= 1'b1;
							core_done_o <= 1'b0;    // stall core
							replay_q    <= 1'b1;
							we_q        <= core_we_i;
							state_q     <= ST_WAIT_READY;
						end
					end
				end

				ST_WAIT_READY: begin
					// a strobe just sent has not yet made the master busy
					if (mem_ready_i && !wb_pend_q && !mem_req_o) begin
						mem_req_o  <= 1'b1;
						mem_rw_o   <= 1'b0;
						mem_addr_o <= {core_tag_i, core_grp_i, {BW_BLOCK{1'b0}}};
						state_q    <= ST_WAIT_REPL;
					end
				end

				ST_WAIT_REPL: begin
					if (victim_rdy_q) begin
						victim_rdy_q <= 1'b0;
						cam_frame_o  <= victim_q;   // old tag readable from next cycle
						ram_addr_o   <= {victim_q, {BW_BLOCK{1'b0}}};
						cnt_q        <= '0;
						if (dirty_q[victim_q]) begin
							flag_writeback_o <= 1'b1;
							state_q          <= ST_WRITE_BUFFER;
						end else begin
							state_q <= ST_READ_BUFFER;
						end
					end
				end

				ST_WRITE_BUFFER: begin
					if (!wbuf_full_i) begin
						cnt_q      <= cnt_q + 1'b1;
						ram_addr_o <= {victim_q, cnt_q + 1'b1};
						if (last_word) begin
							dirty_q[victim_q] <= 1'b0;
							wb_pend_q         <= 1'b1;
							wb_addr_q         <= {cam_tag_i, core_grp_i, {BW_BLOCK{1'b0}}};
							state_q           <= ST_READ_BUFFER;
						end
					end
				end

				ST_READ_BUFFER: begin
					if (!rbuf_empty_i) begin
						ram_we_o   <= 1'b1;
						ram_addr_o <= {victim_q, cnt_q};
						ram_data_o <= rbuf_data_i;
						cnt_q      <= cnt_q + 1'b1;
						if (last_word) begin
							cam_wren_o <= 1'b1;     // core tag into the victim frame
							state_q    <= ST_NORMAL;
						end
					end
				end

				default: state_q <= ST_NORMAL;
			endcase

			// writeback goes out once the fill read has freed the master
			if (wb_pend_q && mem_ready_i && !mem_req_o) begin
				wb_pend_q  <= 1'b0;
				mem_req_o  <= 1'b1;
				mem_rw_o   <= 1'b1;
				mem_addr_o <= wb_addr_q;
			end
		end
	end

endmodule

// ==== src/cache_data_ram.sv ====
`timescale 1ns/1ps

module cache_data_ram (
	input  logic                              clock_i,
	input  logic [cache_pkg::BW_RAM_ADDR-1:0] addr_i,   // frame then word
	input  logic                              we_i,
	input  logic [31:0]                       data_i,
	output logic [31:0]                       data_o
);

	import cache_pkg::*;

	logic [31:0] mem_q [2**BW_RAM_ADDR];

	always_ff @(posedge clock_i) begin
		if (we_i) begin
			mem_q[addr_i] <= data_i;
		end
	end

	assign data_o = mem_q[addr_i];    // asynchronous read

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

	// ------------------------------------------------------------
	// cache geometry
	// ------------------------------------------------------------
	localparam int BW_WORD_ADDR = 16;                        // word addressed memory
	localparam int BW_BLOCK     = 2;                         // word within block
	localparam int BLOCK_WORDS  = 2 ** BW_BLOCK;             // 4 words per block
	localparam int BW_GRP       = 2;                         // set index
	localparam int BW_FRAME     = BW_GRP + 1;                // set followed by way bit
	localparam int CACHE_BLOCKS = 2 ** BW_FRAME;             // 8 frames, 4 sets of 2 ways
	localparam int BW_TAG       = BW_WORD_ADDR - BW_GRP - BW_BLOCK;
	localparam int BW_RAM_ADDR  = BW_FRAME + BW_BLOCK;       // frame then word

	// ------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		ST_NORMAL       = 3'd0,  // hit/miss check
		ST_WAIT_READY   = 3'd1,  // fill request once the bus side is free
		ST_WRITE_BUFFER = 3'd2,  // victim block out to the write buffer
		ST_READ_BUFFER  = 3'd3,  // filled block from the read buffer into the ram
		ST_WAIT_REPL    = 3'd4   // waiting on the victim frame
	} ctrl_state_t;

endpackage

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	// core port
	input  logic                               core_req_i,
	input  logic                               core_we_i,
	input  logic [cache_pkg::BW_WORD_ADDR-1:0] core_addr_i,
	input  logic [31:0]                        core_wdata_i,
	output logic [31:0]                        core_rdata_o,
	output logic                               core_valid_o,
	output logic                               core_done_o,
	// wishbone master
	input  logic [31:0]                        wb_dat_i,
	input  logic                               wb_ack_i,
	output logic                               wb_cyc_o,
	output logic                               wb_stb_o,
	output logic                               wb_we_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] wb_adr_o,
	output logic [31:0]                        wb_dat_o,
	// performance
	output logic                               flag_hit_o,
	output logic                               flag_miss_o,
	output logic                               flag_writeback_o
);

	import cache_pkg::*;

	// ------------------------------------------------------------
	// address split and internal nets
	// ------------------------------------------------------------
	logic [BW_TAG-1:0]       core_tag;
	logic [BW_GRP-1:0]       core_grp;
	logic [BW_BLOCK-1:0]     core_word;
	logic                    cam_hit, cam_wren;
	logic [BW_FRAME-1:0]     cam_hit_frame, cam_frame;
	logic [BW_TAG-1:0]       cam_rd_tag;
	logic [BW_RAM_ADDR-1:0]  ram_addr;
	logic                    ram_we;
	logic [31:0]             ram_wdata, ram_rdata;
	logic                    rbuf_push, rbuf_pop, rbuf_empty, rbuf_full;
	logic [31:0]             rbuf_data;
	logic                    wbuf_push, wbuf_pop, wbuf_empty, wbuf_full;
	logic [31:0]             wbuf_wdata, wbuf_rdata;
	logic                    lru_hit, lru_miss, lru_done;
	logic [BW_FRAME-1:0]     lru_frame;
	logic                    mem_req, mem_rw, mem_ready;
	logic [BW_WORD_ADDR-1:0] mem_addr;

	assign core_tag     = core_addr_i[BW_WORD_ADDR-1:BW_GRP+BW_BLOCK];
	assign core_grp     = core_addr_i[BW_GRP+BW_BLOCK-1:BW_BLOCK];
	assign core_word    = core_addr_i[BW_BLOCK-1:0];
	assign core_rdata_o = ram_rdata;

	cache_2way_controller ctrl0 (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.core_req_i(core_req_i), .core_we_i(core_we_i), .core_tag_i(core_tag),
		.core_grp_i(core_grp), .core_word_i(core_word), .core_data_i(core_wdata_i),
		.core_valid_o(core_valid_o), .core_done_o(core_done_o),
		.cam_hit_i(cam_hit), .cam_frame_i(cam_hit_frame), .cam_tag_i(cam_rd_tag),
		.cam_wren_o(cam_wren), .cam_frame_o(cam_frame),
		.ram_data_i(ram_rdata), .ram_addr_o(ram_addr), .ram_we_o(ram_we),
		.ram_data_o(ram_wdata),
		.rbuf_empty_i(rbuf_empty), .rbuf_data_i(rbuf_data), .rbuf_pop_o(rbuf_pop),
		.wbuf_full_i(wbuf_full), .wbuf_push_o(wbuf_push), .wbuf_data_o(wbuf_wdata),
		.lru_done_i(lru_done), .lru_frame_i(lru_frame),
		.lru_hit_o(lru_hit), .lru_miss_o(lru_miss),
		.mem_ready_i(mem_ready), .mem_req_o(mem_req), .mem_rw_o(mem_rw),
		.mem_addr_o(mem_addr),
		.flag_hit_o(flag_hit_o), .flag_miss_o(flag_miss_o),
		.flag_writeback_o(flag_writeback_o)
	);

	tag_cam cam0 (
		.clock_i(clock_i), .resetn_i(resetn_i), .tag_i(core_tag), .grp_i(core_grp),
		.wren_i(cam_wren), .wr_frame_i(cam_frame), .rd_frame_i(cam_frame),
		.hit_o(cam_hit), .hit_frame_o(cam_hit_frame), .rd_tag_o(cam_rd_tag)
	);

	// hit frame taken from the registered ram address, set along with the hit pulse
	set_lru_policy lru0 (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.hit_i(lru_hit), .hit_frame_i(ram_addr[BW_RAM_ADDR-1:BW_BLOCK]),
		.miss_i(lru_miss), .miss_grp_i(core_grp),
		.done_o(lru_done), .frame_o(lru_frame)
	);

	cache_data_ram ram0 (
		.clock_i(clock_i), .addr_i(ram_addr), .we_i(ram_we),
		.data_i(ram_wdata), .data_o(ram_rdata)
	);

	word_fifo #(.DEPTH(4)) rbuf0 (          // memory to cache
		.clock_i(clock_i), .resetn_i(resetn_i), .push_i(rbuf_push), .data_i(wb_dat_i),
		.pop_i(rbuf_pop), .data_o(rbuf_data), .empty_o(rbuf_empty), .full_o(rbuf_full)
	);

	word_fifo #(.DEPTH(4)) wbuf0 (          // cache to memory
		.clock_i(clock_i), .resetn_i(resetn_i), .push_i(wbuf_push), .data_i(wbuf_wdata),
		.pop_i(wbuf_pop), .data_o(wbuf_rdata), .empty_o(wbuf_empty), .full_o(wbuf_full)
	);

	wb_block_master wbm0 (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.req_i(mem_req), .rw_i(mem_rw), .addr_i(mem_addr), .ready_o(mem_ready),
		.wbuf_data_i(wbuf_rdata), .wbuf_empty_i(wbuf_empty), .wbuf_pop_o(wbuf_pop),
		.rbuf_full_i(rbuf_full), .rbuf_push_o(rbuf_push),
		.wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i), .wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o)
	);

endmodule

// ==== src/set_lru_policy.sv ====
`timescale 1ns/1ps

module set_lru_policy (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic                           hit_i,
	input  logic [cache_pkg::BW_FRAME-1:0] hit_frame_i,
	input  logic                           miss_i,
	input  logic [cache_pkg::BW_GRP-1:0]   miss_grp_i,
	output logic                           done_o,
	output logic [cache_pkg::BW_FRAME-1:0] frame_o
);

	import cache_pkg::*;

	logic [2**BW_GRP-1:0] lru_q;    // least recent way per set

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			lru_q  <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= miss_i;
			if (hit_i) begin
				lru_q[hit_frame_i[BW_FRAME-1:1]] <= ~hit_frame_i[0];  // other way goes stale
			end
		end
	end

	// victim frame, valid with done_o
	always_ff @(posedge clock_i) begin
		if (miss_i) begin
			frame_o <= {miss_grp_i, lru_q[miss_grp_i]};
		end
	end

endmodule

// ==== src/tag_cam.sv ====
`timescale 1ns/1ps

module tag_cam (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic [cache_pkg::BW_TAG-1:0]   tag_i,
	input  logic [cache_pkg::BW_GRP-1:0]   grp_i,
	input  logic                           wren_i,
	input  logic [cache_pkg::BW_FRAME-1:0] wr_frame_i,
	input  logic [cache_pkg::BW_FRAME-1:0] rd_frame_i,
	output logic                           hit_o,
	output logic [cache_pkg::BW_FRAME-1:0] hit_frame_o,
	output logic [cache_pkg::BW_TAG-1:0]   rd_tag_o
);

	import cache_pkg::*;

	logic [CACHE_BLOCKS-1:0] valid_q;
	logic [BW_TAG-1:0]       tag_q [CACHE_BLOCKS];
	logic [BW_FRAME-1:0]     frame0;
	logic [BW_FRAME-1:0]     frame1;
	logic                    hit0;
	logic                    hit1;

	// ------------------------------------------------------------
	// two-way compare within the set
	// ------------------------------------------------------------
	assign frame0 = {grp_i, 1'b0};
	assign frame1 = {grp_i, 1'b1};
	assign hit0   = valid_q[frame0] && (tag_q[frame0] == tag_i);
	assign hit1   = valid_q[frame1] && (tag_q[frame1] == tag_i);

	assign hit_o       = hit0 | hit1;
	assign hit_frame_o = {grp_i, hit1};   // way bit from the matching side
	assign rd_tag_o    = tag_q[rd_frame_i]; // for the writeback address

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (wren_i) begin
			valid_q[wr_frame_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			tag_q[wr_frame_i] <= tag_i;
		end
	end

endmodule

// ==== src/wb_block_master.sv ====
`timescale 1ns/1ps

module wb_block_master (
	input  logic                               clock_i,
	input  logic                               resetn_i,
	// block command
	input  logic                               req_i,
	input  logic                               rw_i,      // 1 writes the block
	input  logic [cache_pkg::BW_WORD_ADDR-1:0] addr_i,
	output logic                               ready_o,
	// buffers
	input  logic [31:0]                        wbuf_data_i,
	input  logic                               wbuf_empty_i,
	output logic                               wbuf_pop_o,
	input  logic                               rbuf_full_i,
	output logic                               rbuf_push_o,
	// wishbone classic
	input  logic [31:0]                        wb_dat_i,
	input  logic                               wb_ack_i,
	output logic                               wb_cyc_o,
	output logic                               wb_stb_o,
	output logic                               wb_we_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] wb_adr_o,
	output logic [31:0]                        wb_dat_o
);

	import cache_pkg::*;

	logic                             busy_q;
	logic                             rw_q;
	logic [BW_WORD_ADDR-BW_BLOCK-1:0] blk_q;    // block part of the address
	logic [BW_BLOCK-1:0]              beat_q;   // word offset
	logic                             beat_ok;
	logic                             beat_done;

	// ------------------------------------------------------------
	// bus signals
	// ------------------------------------------------------------
	assign beat_ok   = rw_q ? !wbuf_empty_i : !rbuf_full_i;  // buffer back-pressure
	assign wb_cyc_o  = busy_q;
	assign wb_stb_o  = busy_q && beat_ok;
	assign wb_we_o   = busy_q && rw_q;
	assign wb_adr_o  = {blk_q, beat_q};
	assign wb_dat_o  = wbuf_data_i;
	assign beat_done = wb_stb_o && wb_ack_i;

	assign wbuf_pop_o  = beat_done && rw_q;
	assign rbuf_push_o = beat_done && !rw_q;   // wb_dat_i feeds the read buffer
	assign ready_o     = !busy_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			busy_q <= 1'b0;
			beat_q <= '0;
		end else if (!busy_q) begin
			if (req_i) begin
				busy_q <= 1'b1;
				beat_q <= '0;
			end
		end else if (beat_done) begin
			beat_q <= beat_q + 1'b1;
			if (beat_q == BW_BLOCK'(BLOCK_WORDS - 1)) begin
				busy_q <= 1'b0;   // cyc drops after the last ack
			end
		end
	end

	// command latch
	always_ff @(posedge clock_i) begin
		if (!busy_q && req_i) begin
			rw_q  <= rw_i;
			blk_q <= addr_i[BW_WORD_ADDR-1:BW_BLOCK];
		end
	end

endmodule

// ==== src/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
	parameter int DEPTH = 4
) (
	input  logic        clock_i,
	input  logic        resetn_i,
	input  logic        push_i,
	input  logic [31:0] data_i,
	input  logic        pop_i,
	output logic [31:0] data_o,
	output logic        empty_o,
	output logic        full_o
);

	logic [31:0]                  mem_q [DEPTH];
	logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
	logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
	logic [$clog2(DEPTH+1)-1:0]   count_q;
	logic                         do_push;
	logic                         do_pop;

	assign empty_o = (count_q == 0);
	assign full_o  = (count_q == DEPTH);
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;
	assign data_o  = mem_q[rd_ptr_q];   // head word

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;  // none or both
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= data_i;
		end
	end

endmodule

// ==== tb/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

	localparam int unsigned SEED       = 32'hde5c;
	localparam logic [31:0] MEM_XOR    = 32'h5a5a_c3c3;
	localparam int          N_DIRECTED = 9;        // accesses in tests 2 to 4
	localparam int          N_RANDOM   = 300;
	localparam int          CYCLE_LIMIT = 60 * (N_DIRECTED + N_RANDOM);

	logic        clock_i;
	logic        resetn_i;
	logic        core_req_i;
	logic        core_we_i;
	logic [15:0] core_addr_i;
	logic [31:0] core_wdata_i;
	logic [31:0] core_rdata_o;
	logic        core_valid_o;
	logic        core_done_o;
	logic [31:0] wb_dat_i;
	logic        wb_ack_i;
	logic        wb_cyc_o;
	logic        wb_stb_o;
	logic        wb_we_o;
	logic [15:0] wb_adr_o;
	logic [31:0] wb_dat_o;
	logic        flag_hit_o;
	logic        flag_miss_o;
	logic        flag_writeback_o;

	// reference model indexed by frame {set, way}
	logic [31:0] shadow [0:65535];
	logic [11:0] ref_tag [8];
	logic [7:0]  ref_valid;
	logic [7:0]  ref_dirty;
	logic [3:0]  ref_lru;                      // least recent way per set
	logic [14:0] bus_q [$];                    // expected bus cycles in order, {we, block}

	int          errors;
	int          err_mark;
	int          n_ok;
	int          n_bad;
	int          beats;
	int          beat_mark;
	int          cycle_cnt;
	int          i;
	logic [1:0]  beat_idx;
	logic [14:0] cur_cyc;
	logic [3:0]  rnd_blk;
	logic [1:0]  rnd_word;
	logic        rnd_we;

	cache_top dut0 (.*);

	wb_mem_model #(.PATTERN(MEM_XOR)) mem0 (
		.clock_i(clock_i), .resetn_i(resetn_i), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o),
		.wb_we_i(wb_we_o), .wb_adr_i(wb_adr_o), .wb_dat_i(wb_dat_o),
		.wb_dat_o(wb_dat_i), .wb_ack_o(wb_ack_i)
	);

	initial begin
		clock_i = 1'b0;
		forever #5 clock_i = ~clock_i;
	end

	// run limit scaled by the access count
	always @(posedge clock_i) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout: no completion within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// checks and reference model
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic predict(input logic we, input logic [15:0] addr, output logic hit,
		output logic wb);
		logic [1:0]  set;
		logic [11:0] tag;
		logic        way;
		int          w;
		set = addr[3:2];
		tag = addr[15:4];
		hit = 1'b0;
		wb  = 1'b0;
		way = ref_lru[set];                    // victim unless a way matches
		for (w = 0; w < 2; w++) begin
			if (ref_valid[{set, w[0]}] && ref_tag[{set, w[0]}] == tag) begin
				hit = 1'b1;
				way = w[0];
			end
		end
		if (!hit) begin
			bus_q.push_back({1'b0, addr[15:2]});      // fill read goes first
			if (ref_dirty[{set, way}]) begin
				wb = 1'b1;
				bus_q.push_back({1'b1, ref_tag[{set, way}], set});  // then the old block
			end
			ref_tag[{set, way}]   = tag;
			ref_valid[{set, way}] = 1'b1;
			ref_dirty[{set, way}] = 1'b0;
		end
		if (we) ref_dirty[{set, way}] = 1'b1;
		ref_lru[set] = ~way;                   // touched way is now most recent
	endtask

	// one core access held until core_valid_o
	// pulses are counted on the way
	task automatic access(input logic we, input logic [15:0] addr, input logic [31:0] wdata);
		logic exp_hit;
		logic exp_wb;
		logic stalled = 1'b0;
		int   n_hit = 0;
		int   n_miss = 0;
		int   n_wb = 0;
		int   n_cyc = 0;
		predict(we, addr, exp_hit, exp_wb);
		core_req_i   = 1'b1;
		core_we_i    = we;
		core_addr_i  = addr;
		core_wdata_i = wdata;
		do begin
			@(negedge clock_i);
			n_cyc++;
			n_hit  += flag_hit_o;
			n_miss += flag_miss_o;
			n_wb   += flag_writeback_o;
			if (!core_done_o) stalled = 1'b1;
		end while (!core_valid_o);
		if (we) shadow[addr] = wdata;
		else check_value("core_rdata_o", core_rdata_o, shadow[addr]);
		check_value("flag_hit_o pulses", n_hit, 1);           // replay counts too
		check_value("flag_miss_o pulses", n_miss, !exp_hit);
		check_value("flag_writeback_o pulses", n_wb, exp_wb);
		check_value("core_done_o low during access", stalled, !exp_hit);
		if (exp_hit) check_value("hit latency in cycles", n_cyc, 1);
		core_req_i = 1'b0;
	endtask

	task automatic drain_bus;
		while (bus_q.size() != 0 || wb_cyc_o) @(negedge clock_i);
	endtask

	task automatic report_test(input string name);
		if (errors == err_mark) begin
			n_ok++;
			$display("[%s] ok", name);
		end else begin
			n_bad++;
			$display("[%s] FAIL with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// every bus beat against the expected cycle and the shadow memory
	always @(posedge clock_i) begin
		if (resetn_i && wb_cyc_o && wb_stb_o && wb_ack_i) begin
			if (beat_idx == 2'd0) begin
				assert (bus_q.size() != 0) else begin
					errors++;
					$display("bus cycle to %h at %0t was not expected", wb_adr_o, $time);
				end
				cur_cyc = {wb_we_o, wb_adr_o[15:2]};
				if (bus_q.size() != 0) cur_cyc = bus_q.pop_front();
			end
			check_value("wb_we_o", wb_we_o, cur_cyc[14]);
			check_value("wb_adr_o", wb_adr_o, {cur_cyc[13:0], beat_idx});
			if (wb_we_o) check_value("wb_dat_o", wb_dat_o, shadow[wb_adr_o]);
			else check_value("wb_dat_i", wb_dat_i, shadow[wb_adr_o]);
			beat_idx = beat_idx + 1'b1;            // wraps after four beats
			beats++;
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(SEED));
		errors    = 0;
		err_mark  = 0;
		n_ok      = 0;
		n_bad     = 0;
		beats     = 0;
		cycle_cnt = 0;
		beat_idx  = 2'd0;
		for (i = 0; i < 65536; i++) begin
			shadow[i] = {16'h0, i[15:0]} ^ MEM_XOR;
		end
		ref_valid = '0;
		ref_dirty = '0;
		ref_lru   = '0;
		resetn_i     = 1'b0;
		core_req_i   = 1'b0;
		core_we_i    = 1'b0;
		core_addr_i  = '0;
		core_wdata_i = '0;
		repeat (3) @(posedge clock_i);
		@(negedge clock_i);
		resetn_i = 1'b1;

		// idle state before any request
		repeat (4) begin
			@(negedge clock_i);
			check_value("core_done_o,core_valid_o,wb_cyc_o,flags",
				{core_done_o, core_valid_o, wb_cyc_o, flag_hit_o, flag_miss_o,
				flag_writeback_o}, 6'b100000);
		end
		report_test("reset_state");

		beat_mark = beats;
		access(1'b0, 16'h1235, '0);                // miss on block 0x48d
		check_value("bus beats for one fill", beats - beat_mark, 4);
		access(1'b0, 16'h1234, '0);
		access(1'b0, 16'h1236, '0);
		access(1'b0, 16'h1237, '0);
		report_test("read_miss_fill");

		beat_mark = beats;
		access(1'b1, 16'h1236, 32'hcafe_0001);
		access(1'b0, 16'h1236, '0);
		check_value("bus beats on write hit", beats - beat_mark, 0);
		report_test("write_hit");

		access(1'b0, 16'h2234, '0);                // second way of set 1
		access(1'b0, 16'h3235, '0);                // evicts the dirty block
		access(1'b0, 16'h1236, '0);                // written word back from memory
		drain_bus;
		report_test("dirty_eviction");

		for (i = 0; i < N_RANDOM; i++) begin
			rnd_blk  = $urandom % 16;
			rnd_word = $urandom % 4;
			rnd_we   = $urandom % 2;
			access(rnd_we, {8'h5a, 2'b00, rnd_blk, rnd_word}, $urandom);
		end
		drain_bus;
		report_test("random_mix");

		$display("summary: %0d tests ok, %0d with errors, %0d failed checks",
			n_ok, n_bad, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== tb/wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model #(
	parameter logic [31:0] PATTERN = 32'h0      // xor'd into each word at start
) (
	input  logic        clock_i,
	input  logic        resetn_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [15:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o
);

	logic [31:0] mem_q [0:65535];
	logic        armed_q;      // wait count already drawn for this beat
	int unsigned wait_q;
	int unsigned waits;
	int          i;

	// every word starts as its own address with the pattern applied
	initial begin
		for (i = 0; i < 65536; i++) begin
			mem_q[i] = {16'h0, i[15:0]} ^ PATTERN;
		end
	end

	// ------------------------------------------------------------
	// classic slave, 0 to 3 wait cycles per beat
	// ------------------------------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			wb_ack_o <= 1'b0;
			armed_q  <= 1'b0;
			wait_q   <= 0;
		end else if (wb_ack_o) begin
			wb_ack_o <= 1'b0;                   // one ack cycle per beat
		end else if (wb_cyc_i && wb_stb_i) begin
			waits = armed_q ? wait_q : ($urandom % 4);
			if (waits == 0) begin
				wb_ack_o <= 1'b1;
				armed_q  <= 1'b0;
				if (wb_we_i) begin
					mem_q[wb_adr_i] <= wb_dat_i;
				end else begin
					wb_dat_o <= mem_q[wb_adr_i];  // valid together with ack
				end
			end else begin
				armed_q <= 1'b1;
				wait_q  <= waits - 1;
			end
		end
	end

endmodule
